// ==== Bender.yml ====
package:
  name: simple_ipod

sources:
  # Package first, then the stages and the top level
  - ipod_pkg.sv
  - key_repeat.sv
  - rate_control.sv
  - playback_control.sv
  - flash_reader.sv
  - hex_display.sv
  - simple_ipod.sv
  - target: test
    files:
      - tb_flash_model.sv
      - tb_simple_ipod.sv

// ==== flash_reader.sv ====
`timescale 1ns/100ps

module flash_reader (
  input  logic                                    CLK_50M,
  input  logic                                    rst_n,
  input  logic                                    fetch_req,
  input  logic [ipod_pkg::SAMPLE_INDEX_WIDTH-1:0] fetch_index,
  output logic                                    flash_mem_read,
  output logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0]   flash_mem_address,
  input  logic                                    flash_mem_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_WIDTH-1:0]   flash_mem_readdata,
  input  logic                                    flash_mem_readdatavalid,
  output logic [ipod_pkg::SAMPLE_WIDTH-1:0]       audio_sample,
  output logic                                    sample_valid
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_DATA
  } rd_state_e;

  rd_state_e   state;
  // Index bit 0, picks the upper or lower 16-bit half
  logic        half_sel;
  logic [15:0] half_word;

  assign half_word = half_sel ? flash_mem_readdata[31:16] : flash_mem_readdata[15:0];

  // ==================================================
  // Read handshake FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state          <= IDLE;
      flash_mem_read <= 1'b0;
      sample_valid   <= 1'b0;
      audio_sample   <= '0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        // Fetches arriving outside IDLE are dropped
        IDLE:
        begin
          if (fetch_req)
          begin
            flash_mem_read <= 1'b1;
            state          <= REQUEST;
          end
        end
        // Hold read and address until waitrequest drops
        REQUEST:
        begin
          if (!flash_mem_waitrequest)
          begin
            flash_mem_read <= 1'b0;
            state          <= WAIT_DATA;
          end
        end
        WAIT_DATA:
        begin
          if (flash_mem_readdatavalid)
          begin
            // Upper byte of the chosen half
            audio_sample <= half_word[15:8];
            sample_valid <= 1'b1;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and half select latched with the request
  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && fetch_req)
    begin
      flash_mem_address <= fetch_index[ipod_pkg::SAMPLE_INDEX_WIDTH-1:1];
      half_sel          <= fetch_index[0];
    end
  end

endmodule

// ==== hex_display.sv ====
`timescale 1ns/100ps

module hex_display (
  input  logic                               CLK_50M,
  input  logic                               rst_n,
  input  logic [ipod_pkg::DIVIDER_WIDTH-1:0] divider,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex0,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex1,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex2,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex3,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex4,
  output logic [ipod_pkg::SEG_WIDTH-1:0]     hex5
);

  localparam int ND = ipod_pkg::HEX_DIGITS;
  localparam int SW = ipod_pkg::SEG_WIDTH;

  logic [4*ND-1:0] value;
  logic [SW-1:0]   seg_q [ND];

  // Active-low segments, bit 6 is g, bit 0 is a
  function automatic logic [SW-1:0] seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // Zero-extend to six nibbles
  assign value = {{(4*ND-ipod_pkg::DIVIDER_WIDTH){1'b0}}, divider};

  // One register per digit, blank out of reset
  always_ff @(posedge CLK_50M)
  begin
    for (int d = 0; d < ND; d++)
    begin
      if (!rst_n)
        seg_q[d] <= '1;
      else
        seg_q[d] <= seg_decode(value[4*d +: 4]);
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

// ==== ipod_pkg.sv ====
package ipod_pkg;

  // ==================================================
  // Flash and sample widths
  // ==================================================

  // Word address into the flash
  localparam int FLASH_ADDR_WIDTH = 23;
  localparam int FLASH_DATA_WIDTH = 32;
  // Two samples per flash word, so one more bit than the address
  localparam int SAMPLE_INDEX_WIDTH = 24;
  localparam int SAMPLE_WIDTH = 8;

  // ==================================================
  // Rate and display
  // ==================================================

  localparam int DIVIDER_WIDTH = 16;
  // Floor for the divider count
  localparam logic [DIVIDER_WIDTH-1:0] MIN_DIVIDER = 16;
  localparam int SEG_WIDTH = 7;
  localparam int HEX_DIGITS = 6;

  // ==================================================
  // Keyboard commands and playback modes
  // ==================================================

  // Opcodes are the plain ASCII codes
  typedef enum logic [7:0] {
    CMD_PLAY     = 8'h45,
    CMD_PAUSE    = 8'h44,
    CMD_FORWARD  = 8'h46,
    CMD_BACKWARD = 8'h42,
    CMD_RESTART  = 8'h52
  } kbd_cmd_e;

  typedef enum logic {
    PAUSED  = 1'b0,
    PLAYING = 1'b1
  } play_state_e;

  typedef enum logic {
    FORWARD  = 1'b0,
    BACKWARD = 1'b1
  } direction_e;

endpackage

// ==== key_repeat.sv ====
`timescale 1ns/100ps

module key_repeat #(
  parameter int unsigned REPEAT_INTERVAL = 5_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [2:0] key_n,
  output logic       speed_up,
  output logic       speed_down,
  output logic       speed_reset
);

  // Wide enough to hold REPEAT_INTERVAL - 1
  localparam int CNT_W = $clog2(REPEAT_INTERVAL + 1);

  // Keys are active low; invert on the way in
  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] rep_cnt;
  logic             rep_wrap;

  // Two-flop synchronizer
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  assign rep_wrap = (rep_cnt == CNT_W'(REPEAT_INTERVAL - 1));

  // Free-running repeat counter, one pulse per held key at each wrap
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rep_cnt    <= '0;
      speed_up   <= 1'b0;
      speed_down <= 1'b0;
    end
    else
    begin
      rep_cnt    <= rep_wrap ? '0 : rep_cnt + 1'b1;
      // key 0 speeds up, key 1 slows down
      speed_up   <= rep_wrap & key_sync[0];
      speed_down <= rep_wrap & key_sync[1];
    end
  end

  // Reset key stays a level
  assign speed_reset = key_sync[2];

endmodule

// ==== playback_control.sv ====
`timescale 1ns/100ps

module playback_control #(
  parameter logic [ipod_pkg::SAMPLE_INDEX_WIDTH-1:0] LAST_SAMPLE = 24'hFFFFF
) (
  input  logic                                    CLK_50M,
  input  logic                                    rst_n,
  input  logic [7:0]                              kbd_ascii,
  input  logic                                    kbd_ready,
  input  logic                                    sample_tick,
  output logic                                    fetch_req,
  output logic [ipod_pkg::SAMPLE_INDEX_WIDTH-1:0] fetch_index
);

  localparam int IW = ipod_pkg::SAMPLE_INDEX_WIDTH;

  ipod_pkg::play_state_e play_state;
  ipod_pkg::direction_e  direction;
  logic [IW-1:0]         index;
  logic [IW-1:0]         index_step;
  logic [IW-1:0]         index_start;

  // Next index in the current direction, wrapping at both ends
  always_comb
  begin
    if (direction == ipod_pkg::FORWARD)
      index_step = (index == LAST_SAMPLE) ? '0 : index + 1'b1;
    else
      index_step = (index == '0) ? LAST_SAMPLE : index - 1'b1;
  end

  // Restart point depends on direction
  assign index_start = (direction == ipod_pkg::FORWARD) ? '0 : LAST_SAMPLE;

  // ==================================================
  // Command decode and index stepping
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play_state <= ipod_pkg::PAUSED;
      direction  <= ipod_pkg::FORWARD;
      index      <= '0;
      fetch_req  <= 1'b0;
    end
    else
    begin
      fetch_req <= 1'b0;
      // Tick uses the state from before this cycle's command
      if (sample_tick && play_state == ipod_pkg::PLAYING)
      begin
        fetch_req <= 1'b1;
        index     <= index_step;
      end
      if (kbd_ready)
      begin
        case (ipod_pkg::kbd_cmd_e'(kbd_ascii))
          ipod_pkg::CMD_PLAY:     play_state <= ipod_pkg::PLAYING;
          ipod_pkg::CMD_PAUSE:    play_state <= ipod_pkg::PAUSED;
          ipod_pkg::CMD_FORWARD:  direction  <= ipod_pkg::FORWARD;
          ipod_pkg::CMD_BACKWARD: direction  <= ipod_pkg::BACKWARD;
          // Restart wins over a step in the same cycle
          ipod_pkg::CMD_RESTART:  index      <= index_start;
          default:                ;
        endcase
      end
    end
  end

  // Index handed to the reader alongside fetch_req
  always_ff @(posedge CLK_50M)
  begin
    if (sample_tick)
      fetch_index <= index;
  end

endmodule

// ==== rate_control.sv ====
`timescale 1ns/100ps

module rate_control #(
  parameter logic [ipod_pkg::DIVIDER_WIDTH-1:0] DEFAULT_DIVIDER = 16'd2272,
  parameter logic [ipod_pkg::DIVIDER_WIDTH-1:0] SPEED_STEP      = 16'd100
) (
  input  logic                               CLK_50M,
  input  logic                               rst_n,
  input  logic                               speed_up,
  input  logic                               speed_down,
  input  logic                               speed_reset,
  output logic [ipod_pkg::DIVIDER_WIDTH-1:0] divider,
  output logic                               sample_tick
);

  localparam int W = ipod_pkg::DIVIDER_WIDTH;

  // One spare bit to catch borrow and carry
  logic [W:0]   div_dec;
  logic [W:0]   div_inc;
  logic         dec_ok;
  logic         inc_ok;
  logic [W-1:0] tick_cnt;
  logic         tick_wrap;

  assign div_dec = {1'b0, divider} - {1'b0, SPEED_STEP};
  assign div_inc = {1'b0, divider} + {1'b0, SPEED_STEP};

  // Faster only while we stay at or above the floor
  assign dec_ok = !div_dec[W] && (div_dec[W-1:0] >= ipod_pkg::MIN_DIVIDER);
  // Slower only without 16-bit overflow
  assign inc_ok = !div_inc[W];

  // ==================================================
  // Divider register
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || speed_reset)
      divider <= DEFAULT_DIVIDER;
    else if (speed_up && dec_ok)
      divider <= div_dec[W-1:0];
    else if (speed_down && inc_ok)
      divider <= div_inc[W-1:0];
  end

  // ==================================================
  // Sample tick
  // ==================================================

  // Compare against the live divider; >= also covers a shrink mid-period
  assign tick_wrap = (tick_cnt >= divider - 1'b1);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else
    begin
      tick_cnt    <= tick_wrap ? '0 : tick_cnt + 1'b1;
      sample_tick <= tick_wrap;
    end
  end

endmodule

// ==== simple_ipod.f ====
ipod_pkg.sv
key_repeat.sv
rate_control.sv
playback_control.sv
flash_reader.sv
hex_display.sv
simple_ipod.sv
tb_flash_model.sv
tb_simple_ipod.sv

// ==== simple_ipod.sv ====
`timescale 1ns/100ps

module simple_ipod #(
  parameter logic [ipod_pkg::DIVIDER_WIDTH-1:0]      DEFAULT_DIVIDER = 16'd2272,
  parameter logic [ipod_pkg::DIVIDER_WIDTH-1:0]      SPEED_STEP      = 16'd100,
  parameter int unsigned                             REPEAT_INTERVAL = 5_000_000,
  parameter logic [ipod_pkg::SAMPLE_INDEX_WIDTH-1:0] LAST_SAMPLE     = 24'hFFFFF
) (
  input  logic                                  CLK_50M,
  input  logic                                  rst_n,
  input  logic [2:0]                            key_n,
  input  logic [7:0]                            kbd_ascii,
  input  logic                                  kbd_ready,
  // Flash read side
  output logic                                  flash_mem_read,
  output logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0] flash_mem_address,
  input  logic                                  flash_mem_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_WIDTH-1:0] flash_mem_readdata,
  input  logic                                  flash_mem_readdatavalid,
  // Audio and display
  output logic [ipod_pkg::SAMPLE_WIDTH-1:0]     audio_sample,
  output logic                                  sample_valid,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex0,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex1,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex2,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex3,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex4,
  output logic [ipod_pkg::SEG_WIDTH-1:0]        hex5
);

  logic                                    speed_up;
  logic                                    speed_down;
  logic                                    speed_reset;
  logic [ipod_pkg::DIVIDER_WIDTH-1:0]      divider;
  logic                                    sample_tick;
  logic                                    fetch_req;
  logic [ipod_pkg::SAMPLE_INDEX_WIDTH-1:0] fetch_index;

  // ==================================================
  // Keys to speed pulses to sample tick
  // ==================================================
  key_repeat #(
    .REPEAT_INTERVAL(REPEAT_INTERVAL)
  ) i_key_repeat (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key_n       (key_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset)
  );

  rate_control #(
    .DEFAULT_DIVIDER(DEFAULT_DIVIDER),
    .SPEED_STEP     (SPEED_STEP)
  ) i_rate_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divider     (divider),
    .sample_tick (sample_tick)
  );

  // ==================================================
  // Playback and flash fetch
  // ==================================================
  playback_control #(
    .LAST_SAMPLE(LAST_SAMPLE)
  ) i_playback_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .kbd_ascii   (kbd_ascii),
    .kbd_ready   (kbd_ready),
    .sample_tick (sample_tick),
    .fetch_req   (fetch_req),
    .fetch_index (fetch_index)
  );

  flash_reader i_flash_reader (
    .CLK_50M                 (CLK_50M),
    .rst_n                   (rst_n),
    .fetch_req               (fetch_req),
    .fetch_index             (fetch_index),
    .flash_mem_read          (flash_mem_read),
    .flash_mem_address       (flash_mem_address),
    .flash_mem_waitrequest   (flash_mem_waitrequest),
    .flash_mem_readdata      (flash_mem_readdata),
    .flash_mem_readdatavalid (flash_mem_readdatavalid),
    .audio_sample            (audio_sample),
    .sample_valid            (sample_valid)
  );

  // Display taps the live divider
  hex_display i_hex_display (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .divider (divider),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

// ==== tb_flash_model.sv ====
`timescale 1ns/100ps

module tb_flash_model #(
  parameter logic [31:0] SEED = 32'h5b31
) (
  input  logic                                  CLK_50M,
  input  logic                                  rst_n,
  input  logic                                  read,
  input  logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0] address,
  output logic                                  waitrequest,
  output logic [ipod_pkg::FLASH_DATA_WIDTH-1:0] readdata,
  output logic                                  readdatavalid
);

  logic [31:0]                           rng;
  // Cycles of waitrequest left for the next request
  logic [1:0]                            stall_left = 2'd0;
  // Cycles until readdatavalid or zero when idle
  logic [2:0]                            lat_left = 3'd0;
  logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0] addr_q;

  initial readdata = '0;
  initial readdatavalid = 1'b0;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fixed content folded from the whole word address
  function automatic logic [31:0] word_hash(input logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0] a);
    logic [7:0] f;
    f = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};
    return {f ^ 8'h3c, f + 8'h91, f * 8'd7, ~f};
  endfunction

  assign waitrequest = (stall_left != 2'd0);

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rng           <= SEED;
      stall_left    <= SEED[1:0];
      lat_left      <= 3'd0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (read && stall_left != 2'd0)
        stall_left <= stall_left - 2'd1;
      else if (read)
      begin
        // On accept pick latency 1 to 4 and the next stall 0 to 3
        addr_q     <= address;
        lat_left   <= 3'd1 + rng[5:4];
        stall_left <= rng[9:8];
        rng        <= xorshift32(rng);
      end
      if (lat_left != 3'd0)
      begin
        lat_left <= lat_left - 3'd1;
        if (lat_left == 3'd1)
        begin
          readdatavalid <= 1'b1;
          readdata      <= word_hash(addr_q);
        end
      end
    end
  end

endmodule

// ==== tb_simple_ipod.sv ====
`timescale 1ns/100ps

module tb_simple_ipod;

  localparam int DEF_DIV = 40;
  localparam int STEP = 4;
  localparam int FLOOR = 16;
  localparam logic [23:0] LAST = 24'd12;

  // Run length from tick periods of all sections plus key holds and code gaps
  localparam int TICK_PERIODS = 80;
  localparam int KEY_CYCLES = 150 + 600 + 150 + 10 + 4 * 10;
  localparam int CODE_CYCLES = 20 * 32;
  localparam int RUN_CYCLES = TICK_PERIODS * DEF_DIV + KEY_CYCLES + CODE_CYCLES;

  logic                                  CLK_50M;
  logic                                  rst_n;
  logic [2:0]                            key_n;
  logic [7:0]                            kbd_ascii;
  logic                                  kbd_ready;
  logic                                  flash_mem_read;
  logic [ipod_pkg::FLASH_ADDR_WIDTH-1:0] flash_mem_address;
  logic                                  flash_mem_waitrequest;
  logic [ipod_pkg::FLASH_DATA_WIDTH-1:0] flash_mem_readdata;
  logic                                  flash_mem_readdatavalid;
  logic [7:0]                            audio_sample;
  logic                                  sample_valid;
  logic [6:0]                            hex0;
  logic [6:0]                            hex1;
  logic [6:0]                            hex2;
  logic [6:0]                            hex3;
  logic [6:0]                            hex4;
  logic [6:0]                            hex5;

  // Reference model of next index, direction (1 is backward) and divider
  logic [23:0] m_idx;
  logic        m_dir;
  int          m_div;
  // Observed activity sampled on the falling edge
  int          sample_count;
  int          read_rises;
  int          cyc;
  int          last_rise;
  int          n_before;
  logic        have_rise;
  logic        spacing_en;
  logic        read_q;
  int          value_errs;
  int          other_errs;
  logic [31:0] rng;
  logic [7:0]  exp_byte;
  logic [23:0] old_div;
  logic [23:0] new_div;
  logic [7:0]  code;

  simple_ipod #(
    .DEFAULT_DIVIDER(16'd40),
    .SPEED_STEP     (16'd4),
    .REPEAT_INTERVAL(60),
    .LAST_SAMPLE    (LAST)
  ) i_dut (
    .CLK_50M                 (CLK_50M),
    .rst_n                   (rst_n),
    .key_n                   (key_n),
    .kbd_ascii               (kbd_ascii),
    .kbd_ready               (kbd_ready),
    .flash_mem_read          (flash_mem_read),
    .flash_mem_address       (flash_mem_address),
    .flash_mem_waitrequest   (flash_mem_waitrequest),
    .flash_mem_readdata      (flash_mem_readdata),
    .flash_mem_readdatavalid (flash_mem_readdatavalid),
    .audio_sample            (audio_sample),
    .sample_valid            (sample_valid),
    .hex0                    (hex0),
    .hex1                    (hex1),
    .hex2                    (hex2),
    .hex3                    (hex3),
    .hex4                    (hex4),
    .hex5                    (hex5)
  );

  tb_flash_model #(
    .SEED(32'h5b31)
  ) i_flash (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .read          (flash_mem_read),
    .address       (flash_mem_address),
    .waitrequest   (flash_mem_waitrequest),
    .readdata      (flash_mem_readdata),
    .readdatavalid (flash_mem_readdatavalid)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Same content as the flash model
  function automatic logic [31:0] word_hash(input logic [22:0] a);
    logic [7:0] f;
    f = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};
    return {f ^ 8'h3c, f + 8'h91, f * 8'd7, ~f};
  endfunction

  // Odd index takes the upper half; sample is that half's upper byte
  function automatic logic [7:0] expected_byte(input logic [23:0] idx);
    logic [31:0] w;
    w = word_hash(idx[23:1]);
    return idx[0] ? w[31:24] : w[15:8];
  endfunction

  function automatic logic is_command(input logic [7:0] c);
    return (c == "E") || (c == "D") || (c == "F") || (c == "B") || (c == "R");
  endfunction

  // Active-low pattern back to {valid, nibble}
  function automatic logic [4:0] seg_nibble(input logic [6:0] seg);
    case (seg)
      7'h40: return 5'h10;
      7'h79: return 5'h11;
      7'h24: return 5'h12;
      7'h30: return 5'h13;
      7'h19: return 5'h14;
      7'h12: return 5'h15;
      7'h02: return 5'h16;
      7'h78: return 5'h17;
      7'h00: return 5'h18;
      7'h10: return 5'h19;
      7'h08: return 5'h1A;
      7'h03: return 5'h1B;
      7'h46: return 5'h1C;
      7'h21: return 5'h1D;
      7'h06: return 5'h1E;
      7'h0E: return 5'h1F;
      default: return 5'h00;
    endcase
  endfunction

  task automatic read_hex(output logic [23:0] value);
    logic [41:0] segs;
    logic [4:0]  dec;
    segs = {hex5, hex4, hex3, hex2, hex1, hex0};
    value = '0;
    for (int d = 0; d < 6; d++)
    begin
      dec = seg_nibble(segs[7*d +: 7]);
      assert (dec[4])
      else
      begin
        $display("Display digit %0d shows no valid hex pattern at %0t", d, $time);
        other_errs++;
      end
      value[4*d +: 4] = dec[3:0];
    end
  endtask

  task automatic check_hex(input logic [23:0] expected);
    logic [23:0] v;
    read_hex(v);
    assert (v == expected)
    else
    begin
      $display("FAILED %0t hex divider got %0d expected %0d", $time, v, expected);
      value_errs++;
    end
  endtask

  // Model follows direction and restart at once since commands land between a sample and a tick
  task automatic send_cmd(input logic [7:0] c);
    kbd_ascii <= c;
    kbd_ready <= 1'b1;
    case (c)
      "F": m_dir = 1'b0;
      "B": m_dir = 1'b1;
      "R": m_idx = m_dir ? LAST : 24'd0;
      default: ;
    endcase
    @(posedge CLK_50M);
    kbd_ready <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int target;
    int waited;
    target = sample_count + n;
    waited = 0;
    while (sample_count < target && waited < n * 2 * DEF_DIV + 32)
    begin
      @(posedge CLK_50M);
      waited++;
    end
    assert (sample_count >= target)
    else
    begin
      $display("Timed out waiting for sample_valid at %0t", $time);
      other_errs++;
    end
  endtask

  // Hold one active-low key, then let the pipeline settle
  task automatic hold_key(input int k, input int cycles);
    key_n[k] <= 1'b0;
    repeat (cycles) @(posedge CLK_50M);
    key_n <= 3'b111;
    repeat (10) @(posedge CLK_50M);
  endtask

  // ==================================================
  // Output monitor and reference model
  // ==================================================
  always @(negedge CLK_50M)
  begin
    if (rst_n)
    begin
      cyc = cyc + 1;
      if (sample_valid)
      begin
        exp_byte = expected_byte(m_idx);
        assert (audio_sample == exp_byte)
        else
        begin
          $display("FAILED %0t audio_sample got %02h expected %02h", $time, audio_sample,
                   exp_byte);
          value_errs++;
        end
        // Step in the direction in force at the tick
        if (!m_dir)
          m_idx = (m_idx == LAST) ? 24'd0 : m_idx + 24'd1;
        else
          m_idx = (m_idx == 24'd0) ? LAST : m_idx - 24'd1;
        sample_count++;
      end
      // Rising edges of the read strobe
      if (flash_mem_read && !read_q)
      begin
        read_rises++;
        if (spacing_en && have_rise)
          assert (cyc - last_rise == m_div)
          else
          begin
            $display("FAILED %0t flash_mem_read spacing got %0d expected %0d", $time,
                     cyc - last_rise, m_div);
            value_errs++;
          end
        last_rise = cyc;
        have_rise = spacing_en;
      end
      if (!spacing_en)
        have_rise = 1'b0;
      read_q = flash_mem_read;
    end
  end

  // Watchdog at twice the planned run length
  initial
  begin
    #(2 * RUN_CYCLES * 20);
    $display("Watchdog expired after %0d cycles, the run did not finish", 2 * RUN_CYCLES);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    $display("TB FAILED");
    $finish;
  end

  // ==================================================
  // Stimulus
  // ==================================================
  initial
  begin
    key_n        = 3'b111;
    kbd_ascii    = 8'h00;
    kbd_ready    = 1'b0;
    rst_n        = 1'b0;
    rng          = 32'h5b31;
    m_idx        = 24'd0;
    m_dir        = 1'b0;
    m_div        = DEF_DIV;
    sample_count = 0;
    read_rises   = 0;
    cyc          = 0;
    last_rise    = 0;
    have_rise    = 1'b0;
    spacing_en   = 1'b0;
    read_q       = 1'b0;
    value_errs   = 0;
    other_errs   = 0;
    repeat (5) @(posedge CLK_50M);
    rst_n <= 1'b1;

    // No reads while paused after reset
    repeat (4 * DEF_DIV) @(posedge CLK_50M);
    assert (read_rises == 0)
    else
    begin
      $display("flash_mem_read was raised while paused after reset");
      other_errs++;
    end
    assert (audio_sample == 8'h00)
    else
    begin
      $display("FAILED %0t audio_sample got %02h expected 00", $time, audio_sample);
      value_errs++;
    end
    check_hex(DEF_DIV);

    // Forward play through the wrap with read spacing checked at 40
    send_cmd("E");
    wait_samples(2);
    spacing_en = 1'b1;
    wait_samples(14);
    spacing_en = 1'b0;

    // Backward through the wrap, then both restart points
    send_cmd("B");
    wait_samples(16);
    send_cmd("R");
    wait_samples(3);
    send_cmd("F");
    send_cmd("R");
    wait_samples(3);

    // Pause at a random point with at most one read in flight
    rng = xorshift32(rng);
    repeat (rng[4:0]) @(posedge CLK_50M);
    send_cmd("D");
    n_before = sample_count;
    repeat (4 * DEF_DIV) @(posedge CLK_50M);
    assert (sample_count - n_before <= 1)
    else
    begin
      $display("More than one sample arrived after pause");
      other_errs++;
    end
    send_cmd("E");
    wait_samples(3);

    // ==================================================
    // Speed keys
    // ==================================================
    read_hex(old_div);
    hold_key(0, 150);
    read_hex(new_div);
    assert (new_div < old_div && (old_div - new_div) % STEP == 0 && new_div >= FLOOR)
    else
    begin
      $display("FAILED %0t hex divider got %0d expected steps of %0d below %0d", $time,
               new_div, STEP, old_div);
      value_errs++;
    end
    // Long hold runs into the floor
    hold_key(0, 600);
    check_hex(FLOOR);
    m_div = FLOOR;
    wait_samples(2);
    spacing_en = 1'b1;
    wait_samples(8);
    spacing_en = 1'b0;
    read_hex(old_div);
    hold_key(1, 150);
    read_hex(new_div);
    assert (new_div > old_div && (new_div - old_div) % STEP == 0)
    else
    begin
      $display("FAILED %0t hex divider got %0d expected steps of %0d above %0d", $time,
               new_div, STEP, old_div);
      value_errs++;
    end
    hold_key(2, 10);
    check_hex(DEF_DIV);
    m_div = DEF_DIV;

    // Random non-command codes leave sequence and speed unchanged
    wait_samples(2);
    spacing_en = 1'b1;
    for (int i = 0; i < 20; i++)
    begin
      rng = xorshift32(rng);
      code = rng[7:0];
      if (is_command(code))
        code = code + 8'h20;
      repeat (rng[12:8]) @(posedge CLK_50M);
      send_cmd(code);
    end
    wait_samples(4);
    spacing_en = 1'b0;
    check_hex(DEF_DIV);

    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
